/* periph_stim.txt */
# cmd addr data expect mask err, all hex; addr bits 11:8 pick the device
# W write, R read, P poll read, G drive gpio_i, Q wait irq_o, O check gpio_o, T end test
W 000 000000A5 0 0 0
R 000 0 000000A5 FFFFFFFF 0
O 000 0 A5 FF 0
T 000 1 0 0 0
G 000 3C 0 0 0
P 004 0 3C FF 0
W 004 FF 0 0 1
T 000 2 0 0 0
G 000 00 0 0 0
P 004 0 00 FF 0
W 008 08 0 0 0
W 204 008 0 0 0
G 000 08 0 0 0
Q 000 1 0 0 0
R 208 0 4 F 0
W 208 4 0 0 0
Q 000 0 0 0 0
R 200 0 0 1FF 0
G 000 28 0 0 0
P 004 0 28 FF 0
R 200 0 0 1FF 0
T 000 3 0 0 0
W 108 1E 0 0 0
W 100 1 0 0 0
P 200 0 100 100 0
W 204 100 0 0 0
R 208 0 9 F 0
Q 000 1 0 0 0
W 108 FFFFFFFF 0 0 0
R 108 0 FFFFFFFF FFFFFFFF 0
W 208 9 0 0 0
R 200 0 0 100 0
Q 000 0 0 0 0
T 000 4 0 0 0
W 008 02 0 0 0
W 204 102 0 0 0
G 000 2A 0 0 0
W 108 1E 0 0 0
P 200 0 102 102 0
R 208 0 2 F 0
W 208 2 0 0 0
R 208 0 9 F 0
W 100 0 0 0 0
R 100 0 0 1 0
W 208 9 0 0 0
R 208 0 0 F 0
Q 000 0 0 0 0
T 000 5 0 0 0
R 700 0 0 FFFFFFFF 1
R 10C 0 0 FFFFFFFF 1
T 000 6 0 0 0

/* sim.f */
periph_pkg.sv
periph_xbar.sv
gpio_block.sv
timer_block.sv
intr_ctrl.sv
periph_top.sv
tb_periph_top.sv

/* Makefile */
SIM      = verilator
TOP      = tb_periph_top
FILELIST = sim.f
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing -Wall
LOG      = sim.log
PASS_MSG = Test OK
BIN      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* tb_periph_top.sv */
// ********************************************************************
// Peripheral subsystem testbench with clock, reset, stimulus file
// player, random back-pressure, checks and result reporting
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_periph_top;

  logic                          clk_i;
  logic                          rst_i;
  logic                          req_valid_i;
  logic                          req_ready_o;
  periph_pkg::bus_req_t          req_i;
  logic                          rsp_valid_o;
  logic                          rsp_ready_i;
  periph_pkg::bus_rsp_t          rsp_o;
  logic [periph_pkg::GPIO_W-1:0] gpio_i;
  logic [periph_pkg::GPIO_W-1:0] gpio_o;
  logic                          irq_o;

  integer seed;
  integer err_cnt;
  integer test_errs;
  integer pass_cnt;
  integer fail_cnt;
  logic   timed_out;

  periph_top u_periph_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .irq_o       (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      err_cnt   = err_cnt + 1;
      test_errs = test_errs + 1;
    end
  endtask

  // One host transfer with the response held back for 0 to 3 cycles
  task automatic bus_xfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    periph_pkg::bus_rsp_t held;
    integer               cnt;
    integer               delay;
    integer               i;
    rdata = '0;
    err   = 1'b0;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.write = write;
    req_i.addr  = addr[periph_pkg::ADDR_W-1:0];
    req_i.wdata = wdata;
    cnt = 0;
    while (!req_ready_o) begin
      @(negedge clk_i);
      cnt = cnt + 1;
      if (cnt > 20) begin
        $display("Timed out waiting for req_ready_o at address %h", addr);
        timed_out = 1'b1;
        return;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    cnt = 0;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      cnt = cnt + 1;
      if (cnt > 20) begin
        $display("Timed out waiting for rsp_valid_o at address %h", addr);
        timed_out = 1'b1;
        return;
      end
    end
    held  = rsp_o;
    delay = $random(seed) & 3;
    for (i = 0; i < delay; i = i + 1) begin
      @(negedge clk_i);
      check_value({31'd0, rsp_valid_o}, 32'd1, "rsp_valid_o dropped under back-pressure");
      check_value({31'd0, req_ready_o}, 32'd0, "req_ready_o high while a response is held");
      check_value(rsp_o.rdata, held.rdata, "rsp_o.rdata changed under back-pressure");
      check_value({31'd0, rsp_o.err}, {31'd0, held.err}, "rsp_o.err changed under back-pressure");
    end
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    rdata = held.rdata;
    err   = held.err;
  endtask

  task automatic run_command(input logic [7:0] cmd, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] expv,
                             input logic [31:0] mask, input logic [31:0] experr);
    logic [31:0] rdata;
    logic        err;
    integer      cnt;
    case (cmd)
      "W": begin
        bus_xfer(1'b1, addr, data, rdata, err);
        if (!timed_out) check_value({31'd0, err}, experr, $sformatf("err of write to %h", addr));
      end
      "R": begin
        bus_xfer(1'b0, addr, 32'd0, rdata, err);
        if (!timed_out) begin
          check_value(rdata & mask, expv & mask, $sformatf("read data at %h", addr));
          check_value({31'd0, err}, experr, $sformatf("err of read at %h", addr));
        end
      end
      "P": begin
        cnt = 0;
        bus_xfer(1'b0, addr, 32'd0, rdata, err);
        while (!timed_out && ((rdata & mask) != (expv & mask))) begin
          cnt = cnt + 1;
          if (cnt > 100) begin
            $display("Timed out polling address %h for value %h", addr, expv);
            timed_out = 1'b1;
          end else begin
            bus_xfer(1'b0, addr, 32'd0, rdata, err);
          end
        end
        if (!timed_out) check_value({31'd0, err}, experr, $sformatf("err of poll at %h", addr));
      end
      "G": begin
        @(negedge clk_i);
        gpio_i = data[periph_pkg::GPIO_W-1:0];
      end
      "Q": begin
        cnt = 0;
        while (!timed_out && (irq_o !== data[0])) begin
          @(negedge clk_i);
          cnt = cnt + 1;
          if (cnt > 200) begin
            $display("Timed out waiting for irq_o to become %0d", data[0]);
            timed_out = 1'b1;
          end
        end
      end
      "O": begin
        check_value({24'd0, gpio_o & mask[7:0]}, {24'd0, expv[7:0] & mask[7:0]}, "gpio_o");
      end
      "T": begin
        if (test_errs == 0) begin
          pass_cnt = pass_cnt + 1;
          $display("test %0d passed", data);
        end else begin
          fail_cnt = fail_cnt + 1;
          $display("test %0d failed with %0d errors", data, test_errs);
        end
        test_errs = 0;
      end
      default: begin
        $display("Unknown command %s in the stimulus file", cmd);
        err_cnt = err_cnt + 1;
      end
    endcase
  endtask

  initial begin
    integer           fd;
    integer           r;
    logic [7:0]       cmd;
    logic [31:0]      addr;
    logic [31:0]      data;
    logic [31:0]      expv;
    logic [31:0]      mask;
    logic [31:0]      experr;
    logic [8*128-1:0] rest;
    seed        = 4776;
    err_cnt     = 0;
    test_errs   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    timed_out   = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    gpio_i      = '0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    fd = $fopen("periph_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file periph_stim.txt");
      err_cnt = err_cnt + 1;
    end else begin
      while (!timed_out) begin
        r = $fscanf(fd, " %c", cmd);
        if (r != 1) break;
        if (cmd == "#") begin
          r = $fgets(rest, fd);
        end else begin
          r = $fscanf(fd, " %h %h %h %h %h", addr, data, expv, mask, experr);
          if (r != 5) begin
            $display("Malformed command line in the stimulus file");
            err_cnt = err_cnt + 1;
            break;
          end
          run_command(cmd, addr, data, expv, mask, experr);
        end
      end
      $fclose(fd);
    end

    $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* periph_top.sv */
// ********************************************************************
// Peripheral subsystem top: crossbar, GPIO, timer, interrupts
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module periph_top (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire logic                          req_valid_i,
  output logic                               req_ready_o,
  input  wire periph_pkg::bus_req_t          req_i,
  output logic                               rsp_valid_o,
  input  wire logic                          rsp_ready_i,
  output periph_pkg::bus_rsp_t               rsp_o,
  input  wire logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0]      gpio_o,
  output logic                               irq_o
);

  periph_pkg::reg_req_t gpio_req;
  periph_pkg::reg_rsp_t gpio_rsp;
  periph_pkg::reg_req_t timer_req;
  periph_pkg::reg_rsp_t timer_rsp;
  periph_pkg::reg_req_t intr_req;
  periph_pkg::reg_rsp_t intr_rsp;

  // Interrupt sources
  logic [periph_pkg::GPIO_W-1:0] gpio_evt;
  logic                          timer_irq;

  periph_xbar u_xbar (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .gpio_req_o  (gpio_req),
    .gpio_rsp_i  (gpio_rsp),
    .timer_req_o (timer_req),
    .timer_rsp_i (timer_rsp),
    .intr_req_o  (intr_req),
    .intr_rsp_i  (intr_rsp)
  );

  gpio_block u_gpio (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .reg_req_i  (gpio_req),
    .reg_rsp_o  (gpio_rsp),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .gpio_evt_o (gpio_evt)
  );

  timer_block u_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_req_i   (timer_req),
    .reg_rsp_o   (timer_rsp),
    .timer_req_o (timer_irq)
  );

  intr_ctrl u_intr (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_req_i   (intr_req),
    .reg_rsp_o   (intr_rsp),
    .gpio_evt_i  (gpio_evt),
    .timer_req_i (timer_irq),
    .irq_o       (irq_o)
  );

endmodule

`default_nettype wire

/* intr_ctrl.sv */
// ********************************************************************
// Interrupt controller: pending, enable, claim/complete, irq output
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module intr_ctrl (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire periph_pkg::reg_req_t          reg_req_i,
  output periph_pkg::reg_rsp_t               reg_rsp_o,
  input  wire logic [periph_pkg::GPIO_W-1:0] gpio_evt_i,
  input  wire logic                          timer_req_i,
  output logic                               irq_o
);

  logic [periph_pkg::NUM_SRC-1:0]  src;
  logic [periph_pkg::NUM_SRC-1:0]  pending_q;
  logic [periph_pkg::NUM_SRC-1:0]  enable_q;
  logic [periph_pkg::NUM_SRC-1:0]  active;
  logic [periph_pkg::NUM_SRC-1:0]  clr_mask;
  logic [periph_pkg::SRC_ID_W-1:0] claim_id;
  logic                            irq_q;
  logic                            complete;
  periph_pkg::intr_reg_e           reg_sel;

  // GPIO pins are IDs 0-7, timer is ID 8
  assign src      = {timer_req_i, gpio_evt_i};
  assign active   = pending_q & enable_q;
  assign reg_sel  = periph_pkg::intr_reg_e'(reg_req_i.offs);
  assign complete = reg_req_i.we && reg_sel == periph_pkg::INTR_CLAIM;

  // Lowest ID wins, search from the top down
  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id = i[periph_pkg::SRC_ID_W-1:0] + 1'b1;
      end
    end
  end

  always_comb begin
    clr_mask = '0;
    for (int i = 0; i < periph_pkg::NUM_SRC; i++) begin
      clr_mask[i] = complete && (reg_req_i.wdata == i + 1);
    end
  end

  // A source still high on completion keeps its bit set
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      irq_q     <= 1'b0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | src;
      irq_q     <= |active;
      if (reg_req_i.we && reg_sel == periph_pkg::INTR_ENABLE) begin
        enable_q <= reg_req_i.wdata[periph_pkg::NUM_SRC-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.err   = 1'b0;
    case (reg_sel)
      periph_pkg::INTR_PENDING: begin
        reg_rsp_o.rdata[periph_pkg::NUM_SRC-1:0] = pending_q;
        reg_rsp_o.err = reg_req_i.we;
      end
      periph_pkg::INTR_ENABLE: reg_rsp_o.rdata[periph_pkg::NUM_SRC-1:0] = enable_q;
      periph_pkg::INTR_CLAIM:  reg_rsp_o.rdata[periph_pkg::SRC_ID_W-1:0] = claim_id;
      default:                 reg_rsp_o.err = 1'b1;
    endcase
  end

  assign irq_o = irq_q;

  a_irq_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(irq_o) |-> $past(|(pending_q & enable_q)));

  a_claim_range: assert property (@(posedge clk_i) disable iff (rst_i)
    claim_id <= periph_pkg::NUM_SRC);

endmodule

`default_nettype wire

/* timer_block.sv */
// ********************************************************************
// Machine timer: mtime counter, compare register, expiry request
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module timer_block (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t      reg_rsp_o,
  output logic                      timer_req_o
);

  logic                          en_q;
  logic [periph_pkg::DATA_W-1:0] mtime_q;
  logic [periph_pkg::DATA_W-1:0] cmp_q;
  logic                          req_q;
  periph_pkg::timer_reg_e        reg_sel;

  assign reg_sel = periph_pkg::timer_reg_e'(reg_req_i.offs);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q  <= 1'b0;
      cmp_q <= '1;
    end else if (reg_req_i.we) begin
      if (reg_sel == periph_pkg::TIMER_CTRL) begin
        en_q <= reg_req_i.wdata[0];
      end
      if (reg_sel == periph_pkg::TIMER_CMP) begin
        cmp_q <= reg_req_i.wdata;
      end
    end
  end

  // Bus write wins over the increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (reg_req_i.we && reg_sel == periph_pkg::TIMER_MTIME) begin
      mtime_q <= reg_req_i.wdata;
    end else if (en_q) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= en_q && (mtime_q >= cmp_q);
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.err   = 1'b0;
    case (reg_sel)
      periph_pkg::TIMER_CTRL:  reg_rsp_o.rdata[0] = en_q;
      periph_pkg::TIMER_MTIME: reg_rsp_o.rdata    = mtime_q;
      periph_pkg::TIMER_CMP:   reg_rsp_o.rdata    = cmp_q;
      default:                 reg_rsp_o.err      = 1'b1;
    endcase
  end

  assign timer_req_o = req_q;

endmodule

`default_nettype wire

/* gpio_block.sv */
// ********************************************************************
// GPIO: output register, input synchronizer, rising-edge events
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module gpio_block (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire periph_pkg::reg_req_t         reg_req_i,
  output periph_pkg::reg_rsp_t              reg_rsp_o,
  input  wire logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0]      gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]      gpio_evt_o
);

  logic [periph_pkg::GPIO_W-1:0] out_q;
  logic [periph_pkg::GPIO_W-1:0] edge_en_q;
  logic [periph_pkg::GPIO_W-1:0] sync1_q;
  logic [periph_pkg::GPIO_W-1:0] sync2_q;
  logic [periph_pkg::GPIO_W-1:0] sync3_q;
  logic [periph_pkg::GPIO_W-1:0] evt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q     <= '0;
      edge_en_q <= '0;
    end else if (reg_req_i.we) begin
      case (periph_pkg::gpio_reg_e'(reg_req_i.offs))
        periph_pkg::GPIO_OUT:     out_q     <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
        periph_pkg::GPIO_EDGE_EN: edge_en_q <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Two sync stages, third one is the previous value for edge detect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
      evt_q   <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      evt_q   <= sync2_q & ~sync3_q & edge_en_q;
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.err   = 1'b0;
    case (periph_pkg::gpio_reg_e'(reg_req_i.offs))
      periph_pkg::GPIO_OUT:     reg_rsp_o.rdata[periph_pkg::GPIO_W-1:0] = out_q;
      periph_pkg::GPIO_EDGE_EN: reg_rsp_o.rdata[periph_pkg::GPIO_W-1:0] = edge_en_q;
      periph_pkg::GPIO_IN: begin
        reg_rsp_o.rdata[periph_pkg::GPIO_W-1:0] = sync2_q;
        // Read only
        reg_rsp_o.err = reg_req_i.we;
      end
      default: reg_rsp_o.err = 1'b1;
    endcase
  end

  assign gpio_o     = out_q;
  assign gpio_evt_o = evt_q;

endmodule

`default_nettype wire

/* periph_xbar.sv */
// ********************************************************************
// Register-bus crossbar: device decode, strobes, held response
// ********************************************************************
`timescale 1ns/100ps
`default_nettype none

module periph_xbar (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic                 req_valid_i,
  output logic                      req_ready_o,
  input  wire periph_pkg::bus_req_t req_i,
  output logic                      rsp_valid_o,
  input  wire logic                 rsp_ready_i,
  output periph_pkg::bus_rsp_t      rsp_o,
  output periph_pkg::reg_req_t      gpio_req_o,
  input  wire periph_pkg::reg_rsp_t gpio_rsp_i,
  output periph_pkg::reg_req_t      timer_req_o,
  input  wire periph_pkg::reg_rsp_t timer_rsp_i,
  output periph_pkg::reg_req_t      intr_req_o,
  input  wire periph_pkg::reg_rsp_t intr_rsp_i
);

  periph_pkg::dev_sel_e dev_sel;
  periph_pkg::reg_req_t base_req;
  periph_pkg::bus_rsp_t rsp_d;
  periph_pkg::bus_rsp_t rsp_q;
  logic                 rsp_valid_q;
  logic                 accept;

  // Keep enables only for the addressed device
  function automatic periph_pkg::reg_req_t gate_req(input periph_pkg::reg_req_t req,
                                                     input logic sel);
    periph_pkg::reg_req_t gated;
    gated    = req;
    gated.we = req.we & sel;
    gated.re = req.re & sel;
    return gated;
  endfunction

  // Free slot, or the held response leaves on this edge
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;
  assign dev_sel     = periph_pkg::dev_sel_e'(req_i.addr[periph_pkg::ADDR_W-1:periph_pkg::OFFS_W]);

  assign base_req.we    = accept & req_i.write;
  assign base_req.re    = accept & ~req_i.write;
  assign base_req.offs  = req_i.addr[periph_pkg::OFFS_W-1:0];
  assign base_req.wdata = req_i.wdata;

  assign gpio_req_o  = gate_req(base_req, dev_sel == periph_pkg::DEV_GPIO);
  assign timer_req_o = gate_req(base_req, dev_sel == periph_pkg::DEV_TIMER);
  assign intr_req_o  = gate_req(base_req, dev_sel == periph_pkg::DEV_INTR);

  always_comb begin
    case (dev_sel)
      periph_pkg::DEV_GPIO:  rsp_d = periph_pkg::bus_rsp_t'(gpio_rsp_i);
      periph_pkg::DEV_TIMER: rsp_d = periph_pkg::bus_rsp_t'(timer_rsp_i);
      periph_pkg::DEV_INTR:  rsp_d = periph_pkg::bus_rsp_t'(intr_rsp_i);
      default: begin
        // unmapped device
        rsp_d.rdata = '0;
        rsp_d.err   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // Response held unchanged under back-pressure
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

  a_one_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({gpio_req_o.we | gpio_req_o.re, timer_req_o.we | timer_req_o.re,
              intr_req_o.we | intr_req_o.re}));

endmodule

`default_nettype wire

/* periph_pkg.sv */
// ********************************************************************
// Shared widths, address map, register offsets and bus structs
// for the peripheral subsystem
// ********************************************************************
`default_nettype none

package periph_pkg;

  localparam int DATA_W   = 32;
  localparam int ADDR_W   = 12;
  localparam int OFFS_W   = 8;
  localparam int GPIO_W   = 8;
  localparam int NUM_SRC  = 9;
  localparam int SRC_ID_W = 4;

  // Device field, address bits 11:8
  typedef enum logic [3:0] {
    DEV_GPIO  = 4'd0,
    DEV_TIMER = 4'd1,
    DEV_INTR  = 4'd2
  } dev_sel_e;

  typedef enum logic [7:0] {
    GPIO_OUT     = 8'h00,
    GPIO_IN      = 8'h04,
    GPIO_EDGE_EN = 8'h08
  } gpio_reg_e;

  typedef enum logic [7:0] {
    TIMER_CTRL  = 8'h00,
    TIMER_MTIME = 8'h04,
    TIMER_CMP   = 8'h08
  } timer_reg_e;

  // Claim reads return ID plus one, 0 means nothing pending
  typedef enum logic [7:0] {
    INTR_PENDING = 8'h00,
    INTR_ENABLE  = 8'h04,
    INTR_CLAIM   = 8'h08
  } intr_reg_e;

  // Host side
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // Device side, enables last one cycle
  typedef struct packed {
    logic              we;
    logic              re;
    logic [OFFS_W-1:0] offs;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } reg_rsp_t;

endpackage

`default_nettype wire
